/* source/matrix_pkg.sv */
// Matrix unit shared types
package matrix_pkg;

  // ------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------

  // Largest row or column count
  localparam int MAT_DIM = 4;

  // Dimension and index width, holds 0 to MAT_DIM
  localparam int DIM_W = 3;

  // Element width
  localparam int ELEM_W = 8;

  // ------------------------------------------------------------------
  // Data types
  // ------------------------------------------------------------------

  typedef logic signed [ELEM_W-1:0] element_t;

  // Cells are addressed as cells[row][col]
  typedef struct packed {
    logic                                is_valid;
    logic [DIM_W-1:0]                    rows;
    logic [DIM_W-1:0]                    cols;
    element_t [MAT_DIM-1:0][MAT_DIM-1:0] cells;
  } matrix_t;

  // OP_CONV and codes 5 to 7 are rejected by the shape check
  typedef enum logic [2:0] {
    OP_ADD        = 3'd0,
    OP_SCALAR_MUL = 3'd1,
    OP_TRANSPOSE  = 3'd2,
    OP_MAT_MUL    = 3'd3,
    OP_CONV       = 3'd4
  } op_code_t;

  // ------------------------------------------------------------------
  // Control between blocks
  // ------------------------------------------------------------------

  typedef struct packed {
    logic             legal;
    logic [DIM_W-1:0] res_rows;
    logic [DIM_W-1:0] res_cols;
    logic [DIM_W-1:0] inner_len;
  } shape_t;

  // Datapath action for the current cycle
  typedef enum logic [1:0] {
    STEP_LOAD  = 2'd0,
    STEP_FETCH = 2'd1,
    STEP_EXEC  = 2'd2,
    STEP_WRITE = 2'd3
  } step_t;

  typedef struct packed {
    logic             active;
    step_t            step;
    op_code_t         op;
    logic [DIM_W-1:0] row;
    logic [DIM_W-1:0] col;
    logic [DIM_W-1:0] inner;
    logic             last;
  } step_cmd_t;

endpackage

/* source/shape_check.sv */
// Operand shape check
`timescale 1ns/100ps

module shape_check import matrix_pkg::*; (
  input  op_code_t op_code_i,
  input  matrix_t  matrix_a_i,
  input  matrix_t  matrix_b_i,
  output shape_t   shape_o
);

  logic a_dims_ok;
  logic b_dims_ok;

  // A used dimension must lie in 1..MAT_DIM
  function automatic logic dim_in_range(input logic [DIM_W-1:0] dim);
    return (dim != '0) && (dim <= DIM_W'(MAT_DIM));
  endfunction

  assign a_dims_ok = dim_in_range(matrix_a_i.rows) && dim_in_range(matrix_a_i.cols);
  assign b_dims_ok = dim_in_range(matrix_b_i.rows) && dim_in_range(matrix_b_i.cols);

  // ------------------------------------------------------------------
  // Legality and result shape per opcode
  // ------------------------------------------------------------------
  always_comb begin
    shape_o = '0;
    case (op_code_i)
      OP_ADD: begin
        shape_o.legal    = a_dims_ok && b_dims_ok &&
                           (matrix_a_i.rows == matrix_b_i.rows) &&
                           (matrix_a_i.cols == matrix_b_i.cols);
        shape_o.res_rows = matrix_a_i.rows;
        shape_o.res_cols = matrix_a_i.cols;
      end
      OP_SCALAR_MUL: begin
        shape_o.legal    = a_dims_ok;
        shape_o.res_rows = matrix_a_i.rows;
        shape_o.res_cols = matrix_a_i.cols;
      end
      // Rows and columns swap places
      OP_TRANSPOSE: begin
        shape_o.legal    = a_dims_ok;
        shape_o.res_rows = matrix_a_i.cols;
        shape_o.res_cols = matrix_a_i.rows;
      end
      OP_MAT_MUL: begin
        shape_o.legal     = a_dims_ok && b_dims_ok &&
                            (matrix_a_i.cols == matrix_b_i.rows);
        shape_o.res_rows  = matrix_a_i.rows;
        shape_o.res_cols  = matrix_b_i.cols;
        shape_o.inner_len = matrix_a_i.cols;
      end
      // Convolution and unused codes
      default: begin
        shape_o.legal = 1'b0;
      end
    endcase
  end

endmodule

/* source/loop_sequencer.sv */
// Matrix operation sequencer
`timescale 1ns/100ps

module loop_sequencer import matrix_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  shape_t      shape_i,
  input  op_code_t    op_code_i,
  output step_cmd_t   cmd_o,
  output logic        done_o,
  output logic        error_o,
  output logic [31:0] cycle_count_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,
    S_DONE
  } seq_state_t;

  seq_state_t       state_q;
  step_t            step_q;
  logic [DIM_W-1:0] row_q;
  logic [DIM_W-1:0] col_q;
  logic [DIM_W-1:0] inner_q;
  logic [31:0]      cycle_q;

  logic is_mat_mul;
  logic last_row;
  logic last_col;
  logic last_inner;
  logic last_cell;
  logic cell_end;

  assign is_mat_mul = (op_code_i == OP_MAT_MUL);
  assign last_row   = (row_q == shape_i.res_rows - DIM_W'(1));
  assign last_col   = (col_q == shape_i.res_cols - DIM_W'(1));
  assign last_inner = (inner_q == shape_i.inner_len - DIM_W'(1));
  assign last_cell  = last_row && last_col;

  // Current cell is finished this cycle
  assign cell_end = (step_q == STEP_WRITE) ||
                    ((step_q == STEP_EXEC) && !is_mat_mul);

  // ------------------------------------------------------------------
  // Command to the datapath
  // ------------------------------------------------------------------
  always_comb begin
    cmd_o       = '0;
    cmd_o.op    = op_code_i;
    cmd_o.row   = row_q;
    cmd_o.col   = col_q;
    cmd_o.inner = inner_q;
    cmd_o.last  = last_cell;
    case (state_q)
      // Load happens on the edge that starts the run
      S_IDLE: begin
        cmd_o.active = start_i && shape_i.legal;
        cmd_o.step   = STEP_LOAD;
      end
      S_EXEC: begin
        cmd_o.active = 1'b1;
        cmd_o.step   = step_q;
      end
      default: begin
        cmd_o.active = 1'b0;
        cmd_o.step   = STEP_LOAD;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // State, loop counters and status
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      step_q  <= STEP_FETCH;
      row_q   <= '0;
      col_q   <= '0;
      inner_q <= '0;
      cycle_q <= '0;
      done_o  <= 1'b0;
      error_o <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            row_q   <= '0;
            col_q   <= '0;
            inner_q <= '0;
            step_q  <= STEP_FETCH;
            cycle_q <= '0;
            error_o <= !shape_i.legal;
            // Bad shapes skip execution entirely
            if (shape_i.legal) begin
              state_q <= S_EXEC;
            end else begin
              state_q <= S_DONE;
              done_o  <= 1'b1;
            end
          end
        end
        S_EXEC: begin
          cycle_q <= cycle_q + 32'd1;
          if (cell_end) begin
            step_q <= STEP_FETCH;
            if (last_col) begin
              col_q <= '0;
              if (last_row) begin
                row_q   <= '0;
                state_q <= S_DONE;
                done_o  <= 1'b1;
              end else begin
                row_q <= row_q + DIM_W'(1);
              end
            end else begin
              col_q <= col_q + DIM_W'(1);
            end
          end else if (step_q == STEP_FETCH) begin
            step_q <= STEP_EXEC;
          end else if (last_inner) begin
            // Dot product complete, write it out next
            inner_q <= '0;
            step_q  <= STEP_WRITE;
          end else begin
            inner_q <= inner_q + DIM_W'(1);
            step_q  <= STEP_FETCH;
          end
        end
        S_DONE: begin
          // Hold done until start is released
          if (!start_i) begin
            state_q <= S_IDLE;
            done_o  <= 1'b0;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign cycle_count_o = cycle_q;

endmodule

/* source/element_datapath.sv */
// Element arithmetic datapath
`timescale 1ns/100ps

module element_datapath import matrix_pkg::*; #(
  parameter int ACC_W = 24
) (
  input  logic      clk,
  input  logic      rst_n,
  input  step_cmd_t cmd_i,
  input  shape_t    shape_i,
  input  matrix_t   matrix_a_i,
  input  matrix_t   matrix_b_i,
  input  element_t  scalar_i,
  output matrix_t   result_o
);

  localparam int IDX_W = $clog2(MAT_DIM);

  typedef logic signed [ACC_W-1:0] acc_t;

  // Clamp limits of a signed element
  localparam acc_t SAT_MAX = acc_t'((2 ** (ELEM_W - 1)) - 1);
  localparam acc_t SAT_MIN = acc_t'(-(2 ** (ELEM_W - 1)));

  acc_t op_a_q;
  acc_t op_b_q;
  acc_t acc_q;
  acc_t prod;
  acc_t sum;
  acc_t elem_val;

  element_t         fetch_a;
  element_t         fetch_b;
  logic [IDX_W-1:0] row;
  logic [IDX_W-1:0] col;
  logic [IDX_W-1:0] inner;

  logic                                valid_q;
  logic [DIM_W-1:0]                    rows_q;
  logic [DIM_W-1:0]                    cols_q;
  element_t [MAT_DIM-1:0][MAT_DIM-1:0] cells_q;

  logic mat_mul;
  logic do_load;
  logic do_fetch;
  logic do_exec;
  logic do_write;
  logic cell_done;

  function automatic element_t saturate(input acc_t value);
    if (value > SAT_MAX) begin
      return SAT_MAX[ELEM_W-1:0];
    end else if (value < SAT_MIN) begin
      return SAT_MIN[ELEM_W-1:0];
    end
    return value[ELEM_W-1:0];
  endfunction

  // ------------------------------------------------------------------
  // Step decode
  // ------------------------------------------------------------------
  assign mat_mul   = (cmd_i.op == OP_MAT_MUL);
  assign do_load   = cmd_i.active && (cmd_i.step == STEP_LOAD);
  assign do_fetch  = cmd_i.active && (cmd_i.step == STEP_FETCH);
  assign do_exec   = cmd_i.active && (cmd_i.step == STEP_EXEC);
  assign do_write  = cmd_i.active && (cmd_i.step == STEP_WRITE);
  assign cell_done = do_write || (do_exec && !mat_mul);

  assign row   = cmd_i.row[IDX_W-1:0];
  assign col   = cmd_i.col[IDX_W-1:0];
  assign inner = cmd_i.inner[IDX_W-1:0];

  // Operand select
  always_comb begin
    fetch_a = matrix_a_i.cells[row][col];
    fetch_b = matrix_b_i.cells[row][col];
    case (cmd_i.op)
      OP_SCALAR_MUL: fetch_b = scalar_i;
      OP_TRANSPOSE: begin
        fetch_a = matrix_a_i.cells[col][row];
        fetch_b = '0;
      end
      OP_MAT_MUL: begin
        fetch_a = matrix_a_i.cells[row][inner];
        fetch_b = matrix_b_i.cells[inner][col];
      end
      default: ;
    endcase
  end

  // One multiplier serves scalar and matrix products
  assign prod = op_a_q * op_b_q;
  assign sum  = op_a_q + op_b_q;

  always_comb begin
    case (cmd_i.op)
      OP_ADD:        elem_val = sum;
      OP_SCALAR_MUL: elem_val = prod;
      default:       elem_val = op_a_q;
    endcase
  end

  // ------------------------------------------------------------------
  // Operand, accumulator and result storage
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (do_load) begin
      rows_q  <= shape_i.res_rows;
      cols_q  <= shape_i.res_cols;
      cells_q <= '0;
      acc_q   <= '0;
    end
    if (do_fetch) begin
      op_a_q <= acc_t'(fetch_a);
      op_b_q <= acc_t'(fetch_b);
    end
    if (do_exec && mat_mul) begin
      acc_q <= acc_q + prod;
    end
    if (cell_done) begin
      cells_q[row][col] <= saturate(do_write ? acc_q : elem_val);
    end
    if (do_write) begin
      acc_q <= '0;
    end
  end

  // Valid once the last cell lands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (do_load) begin
      valid_q <= 1'b0;
    end else if (cell_done && cmd_i.last) begin
      valid_q <= 1'b1;
    end
  end

  always_comb begin
    result_o.is_valid = valid_q;
    result_o.rows     = rows_q;
    result_o.cols     = cols_q;
    result_o.cells    = cells_q;
  end

endmodule

/* source/matrix_alu_top.sv */
// Matrix arithmetic unit top
`timescale 1ns/100ps

module matrix_alu_top import matrix_pkg::*; #(
  // Wide enough for a full dot product of signed bytes
  parameter int ACC_W = 24
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  op_code_t    op_code_i,
  input  matrix_t     matrix_a_i,
  input  matrix_t     matrix_b_i,
  input  element_t    scalar_i,
  output matrix_t     result_o,
  output logic        done_o,
  output logic        error_o,
  output logic [31:0] cycle_count_o
);

  shape_t    shape;
  step_cmd_t cmd;

  // ------------------------------------------------------------------
  // Shape check, zero latency
  // ------------------------------------------------------------------
  shape_check i_shape_check (
    .op_code_i  (op_code_i),
    .matrix_a_i (matrix_a_i),
    .matrix_b_i (matrix_b_i),
    .shape_o    (shape)
  );

  // ------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------
  loop_sequencer i_loop_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .shape_i       (shape),
    .op_code_i     (op_code_i),
    .cmd_o         (cmd),
    .done_o        (done_o),
    .error_o       (error_o),
    .cycle_count_o (cycle_count_o)
  );

  // ------------------------------------------------------------------
  // Arithmetic and result storage
  // ------------------------------------------------------------------
  element_datapath #(
    .ACC_W (ACC_W)
  ) i_element_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_i      (cmd),
    .shape_i    (shape),
    .matrix_a_i (matrix_a_i),
    .matrix_b_i (matrix_b_i),
    .scalar_i   (scalar_i),
    .result_o   (result_o)
  );

endmodule

/* include/matrix_model.svh */
// Matrix unit reference model
`ifndef MATRIX_MODEL_SVH
`define MATRIX_MODEL_SVH

localparam int IDX_W = $clog2(MAT_DIM);

// Signed value of one cell
function automatic int get_cell(input matrix_t m, input int r, input int c);
  element_t e;
  e = m.cells[r[IDX_W-1:0]][c[IDX_W-1:0]];
  return int'(e);
endfunction

task automatic set_cell(inout matrix_t m, input int r, input int c, input int value);
  m.cells[r[IDX_W-1:0]][c[IDX_W-1:0]] = value[ELEM_W-1:0];
endtask

// Clamp to the signed byte range
function automatic int clamp_elem(input int value);
  return (value > 127) ? 127 : ((value < -128) ? -128 : value);
endfunction

function automatic logic dims_ok(input int rows, input int cols);
  return (rows >= 1) && (rows <= MAT_DIM) && (cols >= 1) && (cols <= MAT_DIM);
endfunction

// ----------------------------------------------------------------------
// Expected result, error flag and execute cycles for one operation
// ----------------------------------------------------------------------
task automatic model_op(input logic [2:0] code, input matrix_t a, input matrix_t b,
                        input element_t scalar, output matrix_t ref_res,
                        output logic exp_err, output int exp_cycles);
  int   ar;
  int   ac;
  int   br;
  int   bc;
  int   rows;
  int   cols;
  int   value;
  logic legal;
  ar = int'(a.rows);
  ac = int'(a.cols);
  br = int'(b.rows);
  bc = int'(b.cols);
  legal = 1'b0;
  rows = ar;
  cols = ac;
  ref_res = '0;
  exp_cycles = 0;
  case (code)
    3'd0: legal = dims_ok(ar, ac) && dims_ok(br, bc) && (ar == br) && (ac == bc);
    3'd1: legal = dims_ok(ar, ac);
    3'd2: begin
      legal = dims_ok(ar, ac);
      rows = ac;
      cols = ar;
    end
    3'd3: begin
      legal = dims_ok(ar, ac) && dims_ok(br, bc) && (ac == br);
      cols = bc;
    end
    default: legal = 1'b0;
  endcase
  exp_err = !legal;
  if (legal) begin
    ref_res.is_valid = 1'b1;
    ref_res.rows = DIM_W'(rows);
    ref_res.cols = DIM_W'(cols);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        case (code)
          3'd0: value = get_cell(a, r, c) + get_cell(b, r, c);
          3'd1: value = get_cell(a, r, c) * int'(scalar);
          3'd2: value = get_cell(a, c, r);
          default: begin
            value = 0;
            for (int k = 0; k < ac; k++) begin
              value += get_cell(a, r, k) * get_cell(b, k, c);
            end
          end
        endcase
        set_cell(ref_res, r, c, clamp_elem(value));
      end
    end
    // Fetch and exec per cell, plus a write per dot product
    exp_cycles = (code == 3'd3) ? rows * cols * (2 * ac + 1) : 2 * rows * cols;
  end
endtask

`endif

/* tests/tb_matrix_alu.sv */
// Matrix unit testbench
`timescale 1ns/100ps

module tb_matrix_alu import matrix_pkg::*; ();

  localparam int NUM_RANDOM = 24;
  // Seven shape errors and three saturation runs before the random ones
  localparam int NUM_OPS = 10 + NUM_RANDOM;
  // Longest run is a 4x4 product with inner length 4
  localparam int OP_BOUND = MAT_DIM * MAT_DIM * (2 * MAT_DIM + 1) + 10;
  localparam int WATCHDOG_CYCLES = NUM_OPS * OP_BOUND + 20;

  logic        clk;
  logic        rst_n;
  logic        start;
  op_code_t    op_code;
  matrix_t     matrix_a;
  matrix_t     matrix_b;
  element_t    scalar_in;
  matrix_t     result;
  logic        done;
  logic        error_flag;
  logic [31:0] cycle_count;

  integer seed = 32'h66b2;
  int test_count = 0;
  int tests_failed = 0;
  int fail_count = 0;

  `include "matrix_model.svh"

  matrix_alu_top i_matrix_alu_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start),
    .op_code_i     (op_code),
    .matrix_a_i    (matrix_a),
    .matrix_b_i    (matrix_b),
    .scalar_i      (scalar_in),
    .result_o      (result),
    .done_o        (done),
    .error_o       (error_flag),
    .cycle_count_o (cycle_count)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Fail test %0d: %s expected %h got %h", test_count, name, expected, actual);
    fail_count++;
  endtask

  task automatic finish_test(input string label, input int fails_before);
    if (fail_count == fails_before) begin
      $display("Test %0d %s ok", test_count, label);
    end else begin
      tests_failed++;
      $display("Test %0d %s failed", test_count, label);
    end
  endtask

  function automatic int rand_dim();
    integer rnd;
    rnd = $random(seed);
    return 1 + ((rnd & 32'h7fff_ffff) % MAT_DIM);
  endfunction

  // Random signed bytes in every cell, also outside the used shape
  task automatic random_matrix(output matrix_t m, input int rows, input int cols);
    integer rnd;
    m = '0;
    m.is_valid = 1'b1;
    m.rows = DIM_W'(rows);
    m.cols = DIM_W'(cols);
    for (int r = 0; r < MAT_DIM; r++) begin
      for (int c = 0; c < MAT_DIM; c++) begin
        rnd = $random(seed);
        set_cell(m, r, c, rnd);
      end
    end
  endtask

  // Ramp over the whole cell address
  task automatic ramp_matrix(output matrix_t m, input int rows, input int cols,
                             input int base, input int step);
    m = '0;
    m.is_valid = 1'b1;
    m.rows = DIM_W'(rows);
    m.cols = DIM_W'(cols);
    for (int r = 0; r < MAT_DIM; r++) begin
      for (int c = 0; c < MAT_DIM; c++) begin
        set_cell(m, r, c, base + step * (r * MAT_DIM + c));
      end
    end
  endtask

  task automatic check_outputs(input matrix_t ref_res, input logic exp_err,
                               input int exp_cycles, input int waited);
    if (error_flag !== exp_err) begin
      report_mismatch("error_o", 32'(exp_err), 32'(error_flag));
    end
    if (cycle_count !== 32'(exp_cycles)) begin
      report_mismatch("cycle_count_o", 32'(exp_cycles), cycle_count);
    end
    // Start is seen one edge late, done follows the last execute edge
    if (waited != exp_cycles + 2) begin
      report_mismatch("done_o latency", 32'(exp_cycles + 2), 32'(waited));
    end
    // Error runs come first, so no earlier run has set the valid bit
    if (result.is_valid !== ref_res.is_valid) begin
      report_mismatch("result_o.is_valid", 32'(ref_res.is_valid), 32'(result.is_valid));
    end
    if (!exp_err) begin
      if (result.rows !== ref_res.rows) begin
        report_mismatch("result_o.rows", 32'(ref_res.rows), 32'(result.rows));
      end
      if (result.cols !== ref_res.cols) begin
        report_mismatch("result_o.cols", 32'(ref_res.cols), 32'(result.cols));
      end
      for (int r = 0; r < int'(ref_res.rows); r++) begin
        for (int c = 0; c < int'(ref_res.cols); c++) begin
          if (get_cell(result, r, c) != get_cell(ref_res, r, c)) begin
            report_mismatch($sformatf("result_o.cells[%0d][%0d]", r, c),
                            32'(get_cell(ref_res, r, c) & 32'hff),
                            32'(get_cell(result, r, c) & 32'hff));
          end
        end
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // One operation with the full start and done handshake
  // ----------------------------------------------------------------------
  task automatic run_op(input string label, input logic [2:0] code, input matrix_t a,
                        input matrix_t b, input element_t scalar);
    matrix_t ref_res;
    logic    exp_err;
    int      exp_cycles;
    int      waited;
    int      fails_before;
    test_count++;
    fails_before = fail_count;
    model_op(code, a, b, scalar, ref_res, exp_err, exp_cycles);
    @(posedge clk);
    start     <= 1'b1;
    op_code   <= op_code_t'(code);
    matrix_a  <= a;
    matrix_b  <= b;
    scalar_in <= scalar;
    waited = 1;
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
      waited++;
    end
    check_outputs(ref_res, exp_err, exp_cycles, waited);
    // Done holds as long as start does
    repeat (2) begin
      @(negedge clk);
      if (done !== 1'b1) begin
        report_mismatch("done_o with start_i held", 32'h1, 32'(done));
      end
    end
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    if (done !== 1'b1) begin
      report_mismatch("done_o as start_i falls", 32'h1, 32'(done));
    end
    @(negedge clk);
    if (done !== 1'b0) begin
      report_mismatch("done_o after start_i fell", 32'h0, 32'(done));
    end
    finish_test(label, fails_before);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    matrix_t a;
    matrix_t b;
    int      dim_r;
    int      dim_c;
    int      dim_k;
    integer  rnd;
    rst_n     = 1'b0;
    start     = 1'b0;
    op_code   = OP_ADD;
    matrix_a  = '0;
    matrix_b  = '0;
    scalar_in = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    test_count++;
    @(negedge clk);
    if (done !== 1'b0) begin
      report_mismatch("done_o", 32'h0, 32'(done));
    end
    if (error_flag !== 1'b0) begin
      report_mismatch("error_o", 32'h0, 32'(error_flag));
    end
    if (result.is_valid !== 1'b0) begin
      report_mismatch("result_o.is_valid", 32'h0, 32'(result.is_valid));
    end
    finish_test("reset", 0);

    // Illegal shapes and opcodes
    random_matrix(a, 2, 3);
    random_matrix(b, 3, 3);
    run_op("add mismatch", 3'd0, a, b, '0);
    random_matrix(a, 2, 3);
    random_matrix(b, 2, 2);
    run_op("matmul mismatch", 3'd3, a, b, '0);
    random_matrix(a, 0, 3);
    run_op("zero rows", 3'd1, a, b, 8'sd5);
    random_matrix(a, 2, 2);
    random_matrix(b, 2, 2);
    run_op("conv", 3'd4, a, b, '0);
    for (int code = 5; code < 8; code++) begin
      run_op("unknown opcode", 3'(code), a, b, '0);
    end

    // Saturation at both ends
    ramp_matrix(a, 3, 4, 100, 1);
    ramp_matrix(b, 3, 4, 90, 1);
    run_op("add high", 3'd0, a, b, '0);
    ramp_matrix(a, 4, 2, -100, -1);
    ramp_matrix(b, 4, 2, -90, -1);
    run_op("add low", 3'd0, a, b, '0);
    ramp_matrix(a, 4, 4, 120, -1);
    ramp_matrix(b, 4, 4, 100, 1);
    run_op("matmul high", 3'd3, a, b, '0);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      dim_r = rand_dim();
      dim_c = rand_dim();
      case (i % 4)
        0: begin
          random_matrix(a, dim_r, dim_c);
          random_matrix(b, dim_r, dim_c);
          run_op("add", 3'd0, a, b, '0);
        end
        1: begin
          random_matrix(a, dim_r, dim_c);
          random_matrix(b, dim_r, dim_c);
          rnd = $random(seed);
          run_op("scalar", 3'd1, a, b, rnd[7:0]);
        end
        2: begin
          random_matrix(a, dim_r, dim_c);
          random_matrix(b, dim_c, dim_r);
          run_op("transpose", 3'd2, a, b, '0);
        end
        default: begin
          dim_k = rand_dim();
          random_matrix(a, dim_r, dim_k);
          random_matrix(b, dim_k, dim_c);
          run_op("matmul", 3'd3, a, b, '0);
        end
      endcase
    end

    $display("Summary: %0d tests, %0d failed, %0d mismatches",
             test_count, tests_failed, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
source/matrix_pkg.sv
source/shape_check.sv
source/loop_sequencer.sv
source/element_datapath.sv
source/matrix_alu_top.sv
tests/tb_matrix_alu.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  -f sources.f --top-module tb_matrix_alu \
  && ./obj_dir/Vtb_matrix_alu | tee /dev/stderr | grep -q "^Verification passed$" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
